// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := time_tmr_tb
FILELIST := time_tmr.f
BIN      := obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx '\*\* PASS \*\*'

clean:
	rm -rf obj_dir

// ==== include/time_tmr_consts.svh ====
`ifndef TIME_TMR_CONSTS_SVH
`define TIME_TMR_CONSTS_SVH

// Operation word and result width
`define TMR_DATA_W 32

// Group id width, wraps modulo 4
`define TMR_ID_W 2

// Operand field width
`define TMR_OPND_W 15

// Opcode field width
`define TMR_OPC_W 2

`endif

// ==== logic/time_tmr_end.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "time_tmr_consts.svh"

module time_tmr_end (
    input  wire logic                   clk_i,
    input  wire logic                   rst_i,

    // From the pipeline
    input  wire logic [`TMR_DATA_W-1:0] result_i,
    input  wire logic [`TMR_ID_W-1:0]   id_i,
    input  wire logic                   last_i,
    input  wire logic                   valid_i,
    output logic                        ready_o,

    // Fault injection, copy 3 means none
    input  wire logic [1:0]             fault_copy_i,
    input  wire logic [`TMR_DATA_W-1:0] fault_mask_i,

    // Voted result
    output logic [`TMR_DATA_W-1:0]      result_o,
    output logic                        valid_o,
    output logic                        fault_o,
    input  wire logic                   ready_i
);

    logic [2:0][`TMR_DATA_W-1:0] slot_q;
    logic [1:0]                  cnt_q;
    logic [`TMR_ID_W-1:0]        id_q;

    logic [`TMR_DATA_W-1:0]      res_q;
    logic                        out_valid_q;
    logic                        fault_q;

    logic                        accept;
    logic [`TMR_DATA_W-1:0]      masked;
    logic [2:0][`TMR_DATA_W-1:0] copy;
    logic [`TMR_DATA_W-1:0]      maj;
    logic [`TMR_DATA_W-1:0]      vote_res;
    logic                        vote_fault;

    // Hold off the pipeline while a result waits
    assign ready_o = !out_valid_q || ready_i;
    assign accept  = valid_i && ready_o;

    // Flip bits in the chosen copy only
    assign masked = (fault_copy_i == cnt_q) ? (result_i ^ fault_mask_i) : result_i;

    // Current beat replaces its own slot in the vote
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            if (cnt_q == 2'(i)) begin
                copy[i] = masked;
            end else begin
                copy[i] = slot_q[i];
            end
        end
    end

    // Bit-wise 2 of 3 majority
    assign maj = (copy[0] & copy[1]) | (copy[0] & copy[2]) | (copy[1] & copy[2]);

    always_comb begin
        if (cnt_q == 2'd2) begin
            vote_res   = maj;
            vote_fault = (copy[0] != maj) || (copy[1] != maj) || (copy[2] != maj);
        end else begin
            // Single copy group, nothing to vote
            vote_res   = copy[0];
            vote_fault = 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cnt_q       <= '0;
            out_valid_q <= 1'b0;
            fault_q     <= 1'b0;
        end else begin
            if (accept) begin
                if (last_i) begin
                    cnt_q <= '0;
                end else begin
                    cnt_q <= cnt_q + 1'b1;
                end
            end
            if (accept && last_i) begin
                out_valid_q <= 1'b1;
                fault_q     <= vote_fault;
            end else if (ready_i) begin
                out_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            slot_q[cnt_q] <= masked;
            id_q          <= id_i;
        end
        if (accept && last_i) begin
            res_q <= vote_res;
        end
    end

    assign result_o = res_q;
    assign valid_o  = out_valid_q;
    assign fault_o  = fault_q;

    // Copies of one group share the id given by the start block
    a_group_id: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (accept && cnt_q != 2'd0) |-> id_i == id_q
    );

    // Third copy must close the group
    a_group_size: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (accept && cnt_q == 2'd2) |-> last_i
    );

endmodule

`default_nettype wire

// ==== logic/time_tmr_pkg.sv ====
`default_nettype none

`include "time_tmr_consts.svh"

package time_tmr_pkg;

    // Operations of the arithmetic pipeline
    typedef enum logic [`TMR_OPC_W-1:0] {
        OP_ADD,
        OP_SUB,
        OP_XOR,
        OP_MUL
    } opcode_e;

    // One operation word. The voter and the fault mask see raw bits,
    // the ALU sees opcode and operands
    typedef union packed {
        logic [`TMR_DATA_W-1:0] raw;
        struct packed {
            opcode_e                opc;
            logic [`TMR_OPND_W-1:0] a;
            logic [`TMR_OPND_W-1:0] b;
        } fields;
    } op_word_u;

    // Start block sequence
    typedef enum logic [1:0] {
        STORE_AND_SEND,
        SEND,
        REPLICATE_ONE,
        REPLICATE_TWO
    } start_state_e;

endpackage

`default_nettype wire

// ==== logic/time_tmr_start.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "time_tmr_consts.svh"

module time_tmr_start (
    input  wire logic                   clk_i,
    input  wire logic                   rst_i,
    input  wire logic                   enable_i,

    // Upstream
    input  wire time_tmr_pkg::op_word_u data_i,
    input  wire logic                   valid_i,
    output logic                        ready_o,

    // Downstream
    output time_tmr_pkg::op_word_u      data_o,
    output logic [`TMR_ID_W-1:0]        id_o,
    output logic                        last_o,
    output logic                        valid_o,
    input  wire logic                   ready_i
);

    time_tmr_pkg::start_state_e state_d, state_q;
    time_tmr_pkg::op_word_u     data_d, data_q;
    logic [`TMR_ID_W-1:0]       id_d, id_q;
    // Replication mode latched with the word
    logic                       rep_d, rep_q;

    always_comb begin
        state_d = state_q;
        data_d  = data_q;
        id_d    = id_q;
        rep_d   = rep_q;
        valid_o = 1'b1;
        ready_o = 1'b0;
        last_o  = 1'b0;

        case (state_q)
            time_tmr_pkg::STORE_AND_SEND: begin
                // First copy goes straight through
                ready_o = 1'b1;
                valid_o = valid_i;
                last_o  = !enable_i;
                if (valid_i) begin
                    data_d = data_i;
                    id_d   = id_q + 1'b1;
                    rep_d  = enable_i;
                    if (ready_i) begin
                        if (enable_i) begin
                            state_d = time_tmr_pkg::REPLICATE_ONE;
                        end else begin
                            state_d = time_tmr_pkg::STORE_AND_SEND;
                        end
                    end else begin
                        state_d = time_tmr_pkg::SEND;
                    end
                end
            end
            time_tmr_pkg::SEND: begin
                // Stalled first copy
                last_o = !rep_q;
                if (ready_i) begin
                    if (rep_q) begin
                        state_d = time_tmr_pkg::REPLICATE_ONE;
                    end else begin
                        state_d = time_tmr_pkg::STORE_AND_SEND;
                    end
                end
            end
            time_tmr_pkg::REPLICATE_ONE: begin
                if (ready_i) begin
                    state_d = time_tmr_pkg::REPLICATE_TWO;
                end
            end
            time_tmr_pkg::REPLICATE_TWO: begin
                last_o = 1'b1;
                if (ready_i) begin
                    state_d = time_tmr_pkg::STORE_AND_SEND;
                end
            end
            default: begin
                state_d = time_tmr_pkg::STORE_AND_SEND;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= time_tmr_pkg::STORE_AND_SEND;
            id_q    <= '0;
            rep_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            id_q    <= id_d;
            rep_q   <= rep_d;
        end
    end

    always_ff @(posedge clk_i) begin
        data_q <= data_d;
    end

    // New word and id are visible in the accepting cycle
    assign data_o = data_d;
    assign id_o   = id_d;

    // Upstream is closed while the copies of a replicated word are sent
    a_ready_after_accept: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (ready_o && valid_i && enable_i) |=> !ready_o
    );

    // A pending copy keeps word and id until it leaves
    a_stall_stable: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (state_q != time_tmr_pkg::STORE_AND_SEND && !ready_i)
            |=> $stable(data_o) && $stable(id_o) && $stable(state_q)
    );

endmodule

`default_nettype wire

// ==== logic/time_tmr_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "time_tmr_consts.svh"

module time_tmr_top (
    input  wire logic                   clk_i,
    input  wire logic                   rst_i,
    input  wire logic                   enable_i,

    input  wire time_tmr_pkg::op_word_u data_i,
    input  wire logic                   valid_i,
    output logic                        ready_o,

    input  wire logic [1:0]             fault_copy_i,
    input  wire logic [`TMR_DATA_W-1:0] fault_mask_i,

    output logic [`TMR_DATA_W-1:0]      result_o,
    output logic                        result_valid_o,
    output logic                        fault_o,
    input  wire logic                   result_ready_i
);

    // Start to pipeline
    time_tmr_pkg::op_word_u      s_data;
    logic [`TMR_ID_W-1:0]        s_id;
    logic                        s_last;
    logic                        s_valid;
    logic                        s_ready;

    // Pipeline to end
    logic [`TMR_DATA_W-1:0]      p_result;
    logic [`TMR_ID_W-1:0]        p_id;
    logic                        p_last;
    logic                        p_valid;
    logic                        p_ready;

    time_tmr_start u_start (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .enable_i (enable_i),
        .data_i   (data_i),
        .valid_i  (valid_i),
        .ready_o  (ready_o),
        .data_o   (s_data),
        .id_o     (s_id),
        .last_o   (s_last),
        .valid_o  (s_valid),
        .ready_i  (s_ready)
    );

    tmr_alu_pipe u_pipe (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .op_i     (s_data),
        .id_i     (s_id),
        .last_i   (s_last),
        .valid_i  (s_valid),
        .ready_o  (s_ready),
        .result_o (p_result),
        .id_o     (p_id),
        .last_o   (p_last),
        .valid_o  (p_valid),
        .ready_i  (p_ready)
    );

    time_tmr_end u_end (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .result_i     (p_result),
        .id_i         (p_id),
        .last_i       (p_last),
        .valid_i      (p_valid),
        .ready_o      (p_ready),
        .fault_copy_i (fault_copy_i),
        .fault_mask_i (fault_mask_i),
        .result_o     (result_o),
        .valid_o      (result_valid_o),
        .fault_o      (fault_o),
        .ready_i      (result_ready_i)
    );

endmodule

`default_nettype wire

// ==== logic/tmr_alu_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "time_tmr_consts.svh"

module tmr_alu_pipe (
    input  wire logic                   clk_i,
    input  wire logic                   rst_i,

    input  wire time_tmr_pkg::op_word_u op_i,
    input  wire logic [`TMR_ID_W-1:0]   id_i,
    input  wire logic                   last_i,
    input  wire logic                   valid_i,
    output logic                        ready_o,

    output logic [`TMR_DATA_W-1:0]      result_o,
    output logic [`TMR_ID_W-1:0]        id_o,
    output logic                        last_o,
    output logic                        valid_o,
    input  wire logic                   ready_i
);

    // Stage one holds decoded fields
    logic                      v1_q;
    time_tmr_pkg::opcode_e     opc1_q;
    logic [`TMR_OPND_W-1:0]    a1_q, b1_q;
    logic [`TMR_ID_W-1:0]      id1_q;
    logic                      last1_q;

    // Stage two holds the result
    logic                      v2_q;
    logic [`TMR_DATA_W-1:0]    res2_q;
    logic [`TMR_ID_W-1:0]      id2_q;
    logic                      last2_q;

    logic                      load1, load2;
    logic [`TMR_OPND_W:0]      sum, diff;
    logic [2*`TMR_OPND_W-1:0]  prod;
    logic [`TMR_DATA_W-1:0]    alu_res;

    // Stage two frees up when empty or draining
    assign load2   = v1_q && (!v2_q || ready_i);
    assign ready_o = !v1_q || load2;
    assign load1   = valid_i && ready_o;

    assign sum  = {1'b0, a1_q} + {1'b0, b1_q};
    assign diff = {1'b0, a1_q} - {1'b0, b1_q};
    assign prod = a1_q * b1_q;

    always_comb begin
        alu_res = '0;
        case (opc1_q)
            time_tmr_pkg::OP_ADD: alu_res[`TMR_OPND_W:0] = sum;
            time_tmr_pkg::OP_SUB: alu_res[`TMR_OPND_W:0] = diff;
            time_tmr_pkg::OP_XOR: alu_res[`TMR_OPND_W-1:0] = a1_q ^ b1_q;
            default:              alu_res[2*`TMR_OPND_W-1:0] = prod;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            v1_q <= 1'b0;
            v2_q <= 1'b0;
        end else begin
            if (ready_o) begin
                v1_q <= valid_i;
            end
            if (!v2_q || ready_i) begin
                v2_q <= v1_q;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (load1) begin
            opc1_q  <= op_i.fields.opc;
            a1_q    <= op_i.fields.a;
            b1_q    <= op_i.fields.b;
            id1_q   <= id_i;
            last1_q <= last_i;
        end
        if (load2) begin
            res2_q  <= alu_res;
            id2_q   <= id1_q;
            last2_q <= last1_q;
        end
    end

    assign result_o = res2_q;
    assign id_o     = id2_q;
    assign last_o   = last2_q;
    assign valid_o  = v2_q;

    a_out_hold: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (valid_o && !ready_i)
            |=> valid_o && $stable(result_o) && $stable(id_o) && $stable(last_o)
    );

endmodule

`default_nettype wire

// ==== sim/time_tmr_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "time_tmr_consts.svh"

module time_tmr_tb;

    localparam int N_ROWS         = 12;
    localparam int BURST_N        = 40;
    localparam int TIMEOUT_CYCLES = 16 + 20 * N_ROWS + 30 * BURST_N;

    logic                   clk_i;
    logic                   rst_i;
    logic                   enable_i;
    logic [`TMR_DATA_W-1:0] data_i;
    logic                   valid_i;
    logic                   ready_o;
    logic [1:0]             fault_copy_i;
    logic [`TMR_DATA_W-1:0] fault_mask_i;
    logic [`TMR_DATA_W-1:0] result_o;
    logic                   result_valid_o;
    logic                   fault_o;
    logic                   result_ready_i;

    // Stimulus table, one operation per row
    string                  row_name  [N_ROWS];
    logic [`TMR_DATA_W-1:0] row_word  [N_ROWS];
    logic                   row_en    [N_ROWS];
    logic [1:0]             row_copy  [N_ROWS];
    logic [`TMR_DATA_W-1:0] row_mask  [N_ROWS];
    logic [`TMR_DATA_W-1:0] row_exp   [N_ROWS];
    logic                   row_fault [N_ROWS];
    int                     n_rows;

    logic [`TMR_DATA_W-1:0] exp_q [$];
    logic [31:0]            rng_state;
    int                     errors;
    int                     cycles;
    int                     got;

    time_tmr_top u_dut (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .enable_i       (enable_i),
        .data_i         (data_i),
        .valid_i        (valid_i),
        .ready_o        (ready_o),
        .fault_copy_i   (fault_copy_i),
        .fault_mask_i   (fault_mask_i),
        .result_o       (result_o),
        .result_valid_o (result_valid_o),
        .fault_o        (fault_o),
        .result_ready_i (result_ready_i)
    );

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timeout: run hung after %0d cycles with %0d errors", cycles, errors);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Opcode in the top two bits, then operand a, then operand b
    function automatic logic [`TMR_DATA_W-1:0] alu_model(input logic [`TMR_DATA_W-1:0] word);
        logic [`TMR_OPND_W-1:0] a;
        logic [`TMR_OPND_W-1:0] b;
        logic [`TMR_DATA_W-1:0] res;
        a = word[2*`TMR_OPND_W-1:`TMR_OPND_W];
        b = word[`TMR_OPND_W-1:0];
        case (word[`TMR_DATA_W-1:2*`TMR_OPND_W])
            time_tmr_pkg::OP_ADD: res = 32'(a) + 32'(b);
            time_tmr_pkg::OP_SUB: res = (32'(a) - 32'(b)) & 32'h0000_ffff;
            time_tmr_pkg::OP_XOR: res = 32'(a ^ b);
            default:              res = 32'(a) * 32'(b);
        endcase
        return res;
    endfunction

    task automatic add_row(input string name, input logic [1:0] opc,
                           input logic [14:0] a, input logic [14:0] b, input logic en,
                           input logic [1:0] copy, input logic [31:0] mask);
        logic [`TMR_DATA_W-1:0] word;
        logic [`TMR_DATA_W-1:0] exp;
        word = {opc, a, b};
        exp  = alu_model(word);
        // Single pass has nothing to outvote the mask
        if (!en && copy == 2'd0) begin
            exp = exp ^ mask;
        end
        row_name[n_rows]  = name;
        row_word[n_rows]  = word;
        row_en[n_rows]    = en;
        row_copy[n_rows]  = copy;
        row_mask[n_rows]  = mask;
        row_exp[n_rows]   = exp;
        row_fault[n_rows] = en && copy != 2'd3 && mask != '0;
        n_rows++;
    endtask

    task automatic apply_row(input int i);
        logic took;
        logic seen;
        took = 1'b0;
        seen = 1'b0;
        data_i       = row_word[i];
        enable_i     = row_en[i];
        fault_copy_i = row_copy[i];
        fault_mask_i = row_mask[i];
        valid_i      = 1'b1;
        while (!took) begin
            @(negedge clk_i);
            took = ready_o;
            @(posedge clk_i);
        end
        #2;
        valid_i = 1'b0;
        // Fault inputs stay put until every copy has passed the end block
        while (!seen) begin
            @(negedge clk_i);
            seen = result_valid_o;
            if (!seen) begin
                @(posedge clk_i);
            end
        end
        if (result_o !== row_exp[i]) begin
            $display("ERROR %s: expected %h, actual %h", row_name[i], row_exp[i], result_o);
            errors++;
        end
        if (fault_o !== row_fault[i]) begin
            $display("ERROR %s fault: expected %b, actual %b", row_name[i], row_fault[i],
                     fault_o);
            errors++;
        end
        @(posedge clk_i);
        #2;
        fault_copy_i = 2'd3;
        fault_mask_i = '0;
    endtask

    task automatic run_burst();
        logic [31:0] r;
        logic        took;
        int          sent;
        took = 1'b0;
        sent = 0;
        while (got < BURST_N) begin
            r = next_rand();
            // Sink ready about three cycles in four
            result_ready_i = r[0] | r[1];
            if (took) begin
                valid_i = 1'b0;
            end
            if (!valid_i && sent < BURST_N) begin
                data_i   = next_rand();
                enable_i = r[2] | r[3];
                valid_i  = 1'b1;
            end
            @(negedge clk_i);
            took = valid_i && ready_o;
            if (took) begin
                exp_q.push_back(alu_model(data_i));
                sent++;
            end
            @(posedge clk_i);
            #2;
        end
        valid_i        = 1'b0;
        result_ready_i = 1'b1;
    endtask

    task automatic watch_results();
        logic [`TMR_DATA_W-1:0] exp;
        string                  name;
        while (got < BURST_N) begin
            @(negedge clk_i);
            if (result_valid_o && result_ready_i) begin
                name = $sformatf("burst_%0d", got);
                if (exp_q.size() == 0) begin
                    $display("%s: a result arrived with no word outstanding", name);
                    errors++;
                end else begin
                    exp = exp_q.pop_front();
                    if (result_o !== exp) begin
                        $display("ERROR %s: expected %h, actual %h", name, exp, result_o);
                        errors++;
                    end
                end
                if (fault_o !== 1'b0) begin
                    $display("ERROR %s fault: expected 0, actual %b", name, fault_o);
                    errors++;
                end
                got++;
            end
        end
    endtask

    initial begin
        clk_i          = 1'b0;
        rst_i          = 1'b1;
        enable_i       = 1'b1;
        data_i         = '0;
        valid_i        = 1'b0;
        fault_copy_i   = 2'd3;
        fault_mask_i   = '0;
        result_ready_i = 1'b1;
        rng_state      = 32'h33d3_546d;
        errors         = 0;
        cycles         = 0;
        got            = 0;
        n_rows         = 0;

        add_row("add_carry", time_tmr_pkg::OP_ADD, 15'h7fff, 15'h0001, 1, 3, 32'h0);
        add_row("sub_borrow", time_tmr_pkg::OP_SUB, 15'h0003, 15'h0005, 1, 3, 32'h0);
        add_row("xor_mixed", time_tmr_pkg::OP_XOR, 15'h5555, 15'h7f00, 1, 3, 32'h0);
        add_row("mul_max", time_tmr_pkg::OP_MUL, 15'h7fff, 15'h7fff, 1, 3, 32'h0);
        add_row("add_fault_c0", time_tmr_pkg::OP_ADD, 15'h1234, 15'h0abc, 1, 0,
                32'h8000_0001);
        add_row("sub_fault_c1", time_tmr_pkg::OP_SUB, 15'h4000, 15'h0001, 1, 1,
                32'hffff_ffff);
        add_row("mul_fault_c2", time_tmr_pkg::OP_MUL, 15'h0123, 15'h2345, 1, 2,
                32'h0000_00f0);
        add_row("xor_zero_mask", time_tmr_pkg::OP_XOR, 15'h0f0f, 15'h00ff, 1, 1, 32'h0);
        add_row("single_add", time_tmr_pkg::OP_ADD, 15'h0100, 15'h0200, 0, 3, 32'h0);
        add_row("single_fault_c0", time_tmr_pkg::OP_MUL, 15'h0011, 15'h0022, 0, 0,
                32'h0000_0100);
        add_row("single_fault_c1", time_tmr_pkg::OP_SUB, 15'h0010, 15'h0020, 0, 1,
                32'hffff_ffff);
        add_row("single_fault_c2", time_tmr_pkg::OP_XOR, 15'h7fff, 15'h0000, 0, 2,
                32'h5a5a_5a5a);

        repeat (16) @(posedge clk_i);
        #2;
        rst_i = 1'b0;

        // Idle state right after reset
        @(negedge clk_i);
        if (ready_o !== 1'b1) begin
            $display("ERROR reset_ready: expected 1, actual %b", ready_o);
            errors++;
        end
        if (result_valid_o !== 1'b0) begin
            $display("ERROR reset_valid: expected 0, actual %b", result_valid_o);
            errors++;
        end
        if (fault_o !== 1'b0) begin
            $display("ERROR reset_fault: expected 0, actual %b", fault_o);
            errors++;
        end
        @(posedge clk_i);
        #2;

        for (int i = 0; i < n_rows; i++) begin
            apply_row(i);
        end

        fork
            run_burst();
            watch_results();
        join

        // No extra results may trail the burst
        repeat (8) begin
            @(negedge clk_i);
            if (result_valid_o !== 1'b0) begin
                $display("An extra result appeared after the burst had finished");
                errors++;
            end
        end
        if (exp_q.size() != 0) begin
            $display("%0d burst words never produced a result", exp_q.size());
            errors++;
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== time_tmr.f ====
+incdir+include
logic/time_tmr_pkg.sv
logic/time_tmr_start.sv
logic/tmr_alu_pipe.sv
logic/time_tmr_end.sv
logic/time_tmr_top.sv
sim/time_tmr_tb.sv
